// ==== Makefile ====
# Verilator build and run for the execute slice testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "\*\* FAIL \*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_checker.sv ====
// Scoreboard for the execute slice. Models ALU, multiply and byte memory per issue,
// then compares each retire record taken in a cycle without stall
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  issue,
  input  rv_slice_pkg::issue_t  issue_data,
  input  logic                  stall,
  input  logic                  busy,
  input  rv_slice_pkg::retire_t retire,
  output int                    error_count,
  output int                    retired_count,
  output int                    pending
);

  typedef struct packed {
    rv_slice_pkg::retire_t rec;
    logic                  check_data;  // Low when a load touches unwritten bytes
    logic                  timed;       // Fixed two-edge latency applies
    logic [31:0]           issue_cycle;
    logic [31:0]           stall_snap;
  } expect_t;

  expect_t     exp_q[$];
  logic [7:0]  mem_b [256];
  logic        known [256];
  logic [31:0] cycle;
  logic [31:0] stall_cnt;
  logic        seen_issue;
  logic        mul_run;
  int          mul_steps;

  initial begin
    for (int i = 0; i < 256; i++)
      known[i] = 1'b0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
    error_count++;
  endtask

  task automatic model_issue(input rv_slice_pkg::issue_t t);
    expect_t     e;
    logic [31:0] addr;
    logic [31:0] word;
    logic [7:0]  idx;
    int          nbytes;
    e = '0;
    e.rec.valid     = 1'b1;
    e.rec.reg_write = (t.op != rv_slice_pkg::STORE);
    e.rec.rd        = t.rd;
    e.check_data    = 1'b1;
    e.timed         = (t.op != rv_slice_pkg::MUL);
    e.issue_cycle   = cycle;
    e.stall_snap    = stall_cnt;
    addr   = t.rs1_data + t.imm;
    nbytes = (t.funct3[1:0] == 2'd0) ? 1 : (t.funct3[1:0] == 2'd1) ? 2 : 4;
    word   = '0;
    case (t.op)
      rv_slice_pkg::ADD: e.rec.data = t.rs1_data + t.rs2_data;
      rv_slice_pkg::SUB: e.rec.data = t.rs1_data - t.rs2_data;
      rv_slice_pkg::AND: e.rec.data = t.rs1_data & t.rs2_data;
      rv_slice_pkg::OR:  e.rec.data = t.rs1_data | t.rs2_data;
      rv_slice_pkg::XOR: e.rec.data = t.rs1_data ^ t.rs2_data;
      rv_slice_pkg::SLL: e.rec.data = t.rs1_data << t.rs2_data[4:0];
      rv_slice_pkg::SLT: e.rec.data = {31'b0, $signed(t.rs1_data) < $signed(t.rs2_data)};
      rv_slice_pkg::MUL: e.rec.data = t.rs1_data * t.rs2_data;  // Low word of product
      rv_slice_pkg::LINK: e.rec.data = t.pc + 32'd4;
      rv_slice_pkg::STORE: begin
        e.rec.data = addr;                  // Address passes through on stores
        for (int i = 0; i < nbytes; i++) begin
          idx = addr[7:0] + 8'(i);
          mem_b[idx] = t.rs2_data[8*i +: 8];
          known[idx] = 1'b1;
        end
      end
      default: begin                        // Load
        for (int i = 0; i < nbytes; i++) begin
          idx = addr[7:0] + 8'(i);
          if (!known[idx])
            e.check_data = 1'b0;
          word[8*i +: 8] = mem_b[idx];
        end
        if (!t.funct3[2] && nbytes == 1)
          word = {{24{word[7]}}, word[7:0]};
        else if (!t.funct3[2] && nbytes == 2)
          word = {{16{word[15]}}, word[15:0]};
        e.rec.data = word;
      end
    endcase
    exp_q.push_back(e);
  endtask

  task automatic check_retire();
    expect_t e;
    if (exp_q.size() == 0) begin
      $display("%0t ns: a record retired with no instruction outstanding", $time);
      error_count++;
    end else begin
      e = exp_q.pop_front();
      retired_count++;
      if (retire.reg_write !== e.rec.reg_write)
        report_mismatch("retire.reg_write", 32'(e.rec.reg_write), 32'(retire.reg_write));
      if (retire.rd !== e.rec.rd)
        report_mismatch("retire.rd", 32'(e.rec.rd), 32'(retire.rd));
      if (e.check_data && retire.data !== e.rec.data)
        report_mismatch("retire.data", e.rec.data, retire.data);
      if (e.timed && stall_cnt == e.stall_snap && cycle - e.issue_cycle != 32'd2) begin
        $display("%0t ns: retire came %0d edges after issue instead of two", $time,
                 cycle - e.issue_cycle);
        error_count++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (!reset_n) begin
      error_count   = 0;
      retired_count = 0;
      cycle         = '0;
      stall_cnt     = '0;
      seen_issue    = 1'b0;
      mul_run       = 1'b0;
      mul_steps     = 0;
    end else begin
      cycle++;
      // Each unstalled busy cycle is one multiply step
      if (mul_run) begin
        if (busy) begin
          if (!stall)
            mul_steps++;
        end else begin
          if (mul_steps != rv_slice_pkg::MUL_STEPS) begin
            $display("%0t ns: multiply held busy for %0d unstalled cycles instead of %0d",
                     $time, mul_steps, rv_slice_pkg::MUL_STEPS);
            error_count++;
          end
          mul_run = 1'b0;
        end
      end
      if (!seen_issue && (retire.valid || busy)) begin
        $display("%0t ns: retire.valid or busy high before the first issue", $time);
        error_count++;
      end
      if (retire.valid && !stall)
        check_retire();
      if (issue) begin
        seen_issue = 1'b1;
        model_issue(issue_data);
        if (issue_data.op == rv_slice_pkg::MUL) begin
          mul_run   = 1'b1;
          mul_steps = 0;
        end
      end
      if (stall)
        stall_cnt++;
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
// Testbench top for the execute slice. Issues random instructions by phase,
// raises random stalls in the last phase and reports per-phase counts
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  logic                  clk;
  logic                  reset_n;
  logic                  issue;
  logic                  stall;
  logic                  busy;
  rv_slice_pkg::issue_t  issue_data;
  rv_slice_pkg::retire_t retire;
  int                    error_count;
  int                    retired_count;
  int                    pending;
  int                    issued;
  int                    prev_err;
  int                    prev_ret;
  logic [31:0]           rng;
  logic                  stall_en;

  exec_slice_top UUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .issue      (issue),
    .issue_data (issue_data),
    .stall      (stall),
    .busy       (busy),
    .retire     (retire)
  );

  tb_checker u_checker (
    .clk           (clk),
    .reset_n       (reset_n),
    .issue         (issue),
    .issue_data    (issue_data),
    .stall         (stall),
    .busy          (busy),
    .retire        (retire),
    .error_count   (error_count),
    .retired_count (retired_count),
    .pending       (pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Advance one clock and drive inputs 1 ns after the edge
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    #1;
    r = next_rand();
    stall = stall_en && (r[2:0] == 3'd0);  // About one cycle in eight
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while %s", what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic make_inst(input rv_slice_pkg::op_e op, input logic [7:0] span,
                           output rv_slice_pkg::issue_t t);
    logic [31:0] r;
    logic [31:0] addr;
    t = '0;
    t.op       = op;
    r          = next_rand();
    t.rd       = r[4:0];
    t.rs1_data = next_rand();
    t.rs2_data = next_rand();
    t.imm      = next_rand();
    r          = next_rand();
    t.pc       = {r[31:2], 2'b00};
    if (op == rv_slice_pkg::LOAD || op == rv_slice_pkg::STORE) begin
      r = next_rand();
      if (op == rv_slice_pkg::STORE)
        t.funct3 = 3'(r % 3);
      else
        t.funct3 = (r % 5 < 3) ? 3'(r % 5) : 3'(r % 5 + 1);  // 0,1,2,4,5
      addr = {24'b0, r[15:8] & span};
      if (t.funct3[1:0] == 2'd1)
        addr[0] = 1'b0;
      else if (t.funct3[1:0] == 2'd2)
        addr[1:0] = 2'b00;
      t.imm      = {{20{r[27]}}, r[27:16]};
      t.rs1_data = addr - t.imm;
    end
  endtask

  task automatic issue_inst(input rv_slice_pkg::issue_t t);
    int n;
    n = 0;
    while (busy) begin
      step();
      n++;
      if (n > 100)
        abort_run("waiting for busy to fall");
    end
    issue      = 1'b1;
    issue_data = t;
    issued++;
    step();
    issue = 1'b0;
  endtask

  // kind 0 ALU and LINK, 1 MUL, 2 store, 3 load, 4 any op
  task automatic run_phase(input int kind, input int count, input logic [7:0] span);
    rv_slice_pkg::issue_t t;
    rv_slice_pkg::op_e    op;
    logic [31:0]          r;
    for (int i = 0; i < count; i++) begin
      r = next_rand();
      case (kind)
        0:       op = (r % 8 == 7) ? rv_slice_pkg::LINK : rv_slice_pkg::op_e'(4'(r % 7));
        1:       op = rv_slice_pkg::MUL;
        2:       op = rv_slice_pkg::STORE;
        3:       op = rv_slice_pkg::LOAD;
        default: op = rv_slice_pkg::op_e'(4'(r % 11));
      endcase
      make_inst(op, span, t);
      issue_inst(t);
      if (r[30:29] == 2'b00)
        step();                             // Occasional idle gap
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pending != 0 || busy) begin
      step();
      n++;
      if (n > 400)
        abort_run("draining the pipeline");
    end
    repeat (3) step();
  endtask

  task automatic report_phase(input string name);
    $display("%-12s retired %0d errors %0d", name, retired_count - prev_ret,
             error_count - prev_err);
    prev_ret = retired_count;
    prev_err = error_count;
  endtask

  initial begin
    rng        = 32'ha8df5eee;
    reset_n    = 1'b0;
    issue      = 1'b0;
    issue_data = '0;
    stall      = 1'b0;
    stall_en   = 1'b0;
    issued     = 0;
    prev_err   = 0;
    prev_ret   = 0;
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;
    repeat (6) step();
    report_phase("reset");
    run_phase(0, 60, 8'hff);
    drain();
    report_phase("alu_link");
    run_phase(1, 12, 8'hff);
    drain();
    report_phase("mul");
    run_phase(2, 24, 8'h3f);                // Small window so loads hit written bytes
    run_phase(3, 30, 8'h3f);
    drain();
    report_phase("store_load");
    stall_en = 1'b1;
    run_phase(4, 120, 8'h3f);
    stall_en = 1'b0;
    drain();
    report_phase("stall_mix");
    $display("issued %0d retired %0d errors %0d", issued, retired_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
// Execute stage. ALU ops, LINK and address generation pass through combinationally,
// MUL runs as a two-bit-per-cycle shift-add loop while busy is high.
// An instruction issued during a stall is held here until the stall ends.
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  issue,
  input  rv_slice_pkg::issue_t  issue_data,
  input  logic                  stall,
  output logic                  busy,
  output rv_slice_pkg::ex_mem_t ex_out
);

  rv_slice_pkg::issue_t               cur;        // Accepted instruction
  logic                               cur_valid;
  logic [rv_slice_pkg::MUL_CNT_W-1:0] step_cnt;
  logic [rv_slice_pkg::XLEN-1:0]      mcand;
  logic [rv_slice_pkg::XLEN-1:0]      mplier;
  logic [rv_slice_pkg::XLEN-1:0]      prod;

  rv_slice_pkg::issue_t               inst;
  logic [rv_slice_pkg::XLEN-1:0]      partial;
  logic [rv_slice_pkg::XLEN-1:0]      mul_result;
  logic [rv_slice_pkg::XLEN-1:0]      alu_result;
  logic                               is_mul;
  logic                               mul_done;

  assign inst     = issue ? issue_data : cur;       // New issue wins, stage is idle then
  assign is_mul   = (inst.op == rv_slice_pkg::MUL);
  assign mul_done = cur_valid && (step_cnt == rv_slice_pkg::MUL_LAST);
  assign busy     = cur_valid;

  // Two multiplier bits per step, low word only
  assign partial    = (mplier[0] ? mcand : '0) +
                      (mplier[1] ? {mcand[rv_slice_pkg::XLEN-2:0], 1'b0} : '0);
  assign mul_result = prod + partial;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cur_valid <= 1'b0;
      step_cnt  <= '0;
    end else if (issue) begin
      cur_valid <= stall || (issue_data.op == rv_slice_pkg::MUL);
      step_cnt  <= '0;
    end else if (cur_valid && !stall) begin
      if (cur.op == rv_slice_pkg::MUL && !mul_done)
        step_cnt <= step_cnt + 1'b1;
      else
        cur_valid <= 1'b0;                          // Leaves with the EX/MEM capture
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      cur    <= issue_data;
      mcand  <= issue_data.rs1_data;
      mplier <= issue_data.rs2_data;
      prod   <= '0;
    end else if (cur_valid && !stall && cur.op == rv_slice_pkg::MUL && !mul_done) begin
      mcand  <= {mcand[rv_slice_pkg::XLEN-3:0], 2'b00};
      mplier <= mplier >> 2;
      prod   <= mul_result;
    end
  end

  always_comb begin
    case (inst.op)
      rv_slice_pkg::ADD: alu_result = inst.rs1_data + inst.rs2_data;
      rv_slice_pkg::SUB: alu_result = inst.rs1_data - inst.rs2_data;
      rv_slice_pkg::AND: alu_result = inst.rs1_data & inst.rs2_data;
      rv_slice_pkg::OR:  alu_result = inst.rs1_data | inst.rs2_data;
      rv_slice_pkg::XOR: alu_result = inst.rs1_data ^ inst.rs2_data;
      rv_slice_pkg::SLL: alu_result = inst.rs1_data << inst.rs2_data[4:0];
      rv_slice_pkg::SLT: begin
        alu_result = '0;
        alu_result[0] = $signed(inst.rs1_data) < $signed(inst.rs2_data);
      end
      rv_slice_pkg::MUL: alu_result = mul_result;   // Final step presents the product
      default:           alu_result = inst.rs1_data + inst.imm;  // LOAD, STORE, LINK
    endcase
  end

  always_comb begin
    ex_out.valid      = (issue || cur_valid) && (!is_mul || mul_done);
    ex_out.reg_write  = (inst.op != rv_slice_pkg::STORE);
    ex_out.mem_read   = (inst.op == rv_slice_pkg::LOAD);
    ex_out.mem_write  = (inst.op == rv_slice_pkg::STORE);
    if (inst.op == rv_slice_pkg::LOAD)
      ex_out.wb_sel = rv_slice_pkg::MEM;
    else if (inst.op == rv_slice_pkg::LINK)
      ex_out.wb_sel = rv_slice_pkg::PC4;
    else
      ex_out.wb_sel = rv_slice_pkg::ALU;
    ex_out.funct3     = inst.funct3;
    ex_out.rd         = inst.rd;
    ex_out.alu_result = alu_result;
    ex_out.store_data = inst.rs2_data;
    ex_out.pc_plus_4  = inst.pc + rv_slice_pkg::XLEN'(4);
  end

endmodule

`default_nettype wire

// ==== source/exec_slice_top.sv ====
// Top of the execute slice. Issue enters the execute stage, passes EX/MEM,
// the memory stage and MEM/WB, and leaves on the retire port; stall freezes both registers
`timescale 1ns/1ps
`default_nettype none

module exec_slice_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  issue,
  input  rv_slice_pkg::issue_t  issue_data,
  input  logic                  stall,
  output logic                  busy,
  output rv_slice_pkg::retire_t retire
);

  rv_slice_pkg::ex_mem_t ex_out;
  rv_slice_pkg::ex_mem_t ex_mem_q;
  rv_slice_pkg::retire_t retire_next;

  ex_stage u_ex_stage (
    .clk        (clk),
    .reset_n    (reset_n),
    .issue      (issue),
    .issue_data (issue_data),
    .stall      (stall),
    .busy       (busy),
    .ex_out     (ex_out)
  );

  pipe_register #(.payload_t(rv_slice_pkg::ex_mem_t)) ex_mem_reg (
    .clk     (clk),
    .reset_n (reset_n),
    .hold    (stall),
    .d       (ex_out),
    .q       (ex_mem_q)
  );

  mem_stage u_mem_stage (
    .clk         (clk),
    .stall       (stall),
    .ex_in       (ex_mem_q),
    .retire_next (retire_next)
  );

  pipe_register #(.payload_t(rv_slice_pkg::retire_t)) mem_wb_reg (
    .clk     (clk),
    .reset_n (reset_n),
    .hold    (stall),
    .d       (retire_next),
    .q       (retire)
  );

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
// Memory stage with a small word-wide data RAM. Stores are byte-enabled at the clock
// edge, loads read asynchronously and are extended by funct3 before write-back select.
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                  clk,
  input  logic                  stall,
  input  rv_slice_pkg::ex_mem_t ex_in,
  output rv_slice_pkg::retire_t retire_next
);

  logic [rv_slice_pkg::XLEN-1:0]    dmem [rv_slice_pkg::DMEM_WORDS];
  logic [rv_slice_pkg::DMEM_AW-1:0] word_idx;
  logic [1:0]                       lane;
  logic [3:0]                       byte_en;
  logic [rv_slice_pkg::XLEN-1:0]    wr_data;
  logic [rv_slice_pkg::XLEN-1:0]    rd_word;
  logic [rv_slice_pkg::XLEN-1:0]    shifted;
  logic [rv_slice_pkg::XLEN-1:0]    load_data;
  logic                             store_now;

  assign word_idx  = ex_in.alu_result[rv_slice_pkg::DMEM_AW+1:2];  // Wraps modulo RAM size
  assign lane      = ex_in.alu_result[1:0];
  assign store_now = ex_in.valid && ex_in.mem_write && !stall;

  // Replicate store data across lanes and enable only the addressed bytes
  always_comb begin
    case (ex_in.funct3[1:0])
      2'b00: begin
        byte_en = 4'b0001 << lane;
        wr_data = {4{ex_in.store_data[7:0]}};
      end
      2'b01: begin
        byte_en = lane[1] ? 4'b1100 : 4'b0011;
        wr_data = {2{ex_in.store_data[15:0]}};
      end
      default: begin
        byte_en = 4'b1111;
        wr_data = ex_in.store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (store_now) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b])
          dmem[word_idx][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

  assign rd_word = dmem[word_idx];
  assign shifted = rd_word >> {lane, 3'b000};         // Addressed byte or half to bit 0

  always_comb begin
    case (ex_in.funct3)
      3'b000:  load_data = {{(rv_slice_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};    // LB
      3'b001:  load_data = {{(rv_slice_pkg::XLEN-16){shifted[15]}}, shifted[15:0]}; // LH
      3'b100:  load_data = {{(rv_slice_pkg::XLEN-8){1'b0}}, shifted[7:0]};          // LBU
      3'b101:  load_data = {{(rv_slice_pkg::XLEN-16){1'b0}}, shifted[15:0]};        // LHU
      default: load_data = rd_word;                                                 // LW
    endcase
  end

  always_comb begin
    retire_next.valid     = ex_in.valid;
    retire_next.reg_write = ex_in.reg_write;
    retire_next.rd        = ex_in.rd;
    case (ex_in.wb_sel)
      rv_slice_pkg::MEM: retire_next.data = load_data;
      rv_slice_pkg::PC4: retire_next.data = ex_in.pc_plus_4;
      default:           retire_next.data = ex_in.alu_result;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/pipe_register.sv ====
// Pipeline register for any packed payload, cleared on reset
// While hold is high the stored record stays in place, used for EX/MEM and MEM/WB
`timescale 1ns/1ps
`default_nettype none

module pipe_register #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     hold,     // Data memory not ready
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      q <= '0;               // Valid bit clears with the rest
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== source/rv_slice_pkg.sv ====
// Shared widths, operation encodings and stage payload types for the execute slice
// Design and testbench files refer to these through rv_slice_pkg:: scoped names
`default_nettype none

package rv_slice_pkg;

  localparam int XLEN       = 32;
  localparam int DMEM_WORDS = 64;                  // 256 bytes of data RAM
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // Word index taken from address bits 7:2
  localparam int MUL_STEPS  = 16;                  // Two multiplier bits per step
  localparam int MUL_CNT_W  = $clog2(MUL_STEPS);
  localparam logic [MUL_CNT_W-1:0] MUL_LAST = MUL_CNT_W'(MUL_STEPS - 1);

  // Operation carried by an issued instruction
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLL, SLT,
    MUL,
    LOAD, STORE,
    LINK                                           // Writes pc+4 back, stands in for jumps
  } op_e;

  typedef enum logic [1:0] {
    ALU,
    MEM,
    PC4
  } wb_sel_e;

  typedef struct packed {
    op_e             op;
    logic [2:0]      funct3;                       // Access size and signedness
    logic [4:0]      rd;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
  } issue_t;

  typedef struct packed {
    logic            valid;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    wb_sel_e         wb_sel;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [XLEN-1:0] alu_result;                   // Also the memory address
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] pc_plus_4;
  } ex_mem_t;

  // Write-back record, also the retire port
  typedef struct packed {
    logic            valid;
    logic            reg_write;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } retire_t;

endpackage

`default_nettype wire

// ==== src.f ====
source/rv_slice_pkg.sv
source/ex_stage.sv
source/pipe_register.sv
source/mem_stage.sv
source/exec_slice_top.sv
dv/tb_checker.sv
dv/tb_top.sv
